/* hw/tage_bank.sv */
`default_nettype none

`include "tage_consts.svh"

module tage_bank (
    input  wire       clk,
    input  wire       reset,
    input  wire       flush_ubits_hi,
    input  wire       flush_ubits_lo,
    tage_bank_if.bank port
);

    localparam int ENTRIES = 1 << `TAGE_INDEX_W;
    localparam int UW      = `TAGE_USEFUL_W;

    logic                   valid_q  [ENTRIES];
    tage_pkg::tage_tag_t    tag_q    [ENTRIES];
    tage_pkg::tage_ctr_t    ctr_q    [ENTRIES];
    tage_pkg::tage_useful_t useful_q [ENTRIES];

    tage_pkg::tage_useful_t useful_cur; // entry addressed by the update
    logic                   useful_max;
    logic                   useful_zero;

    assign useful_cur  = useful_q[port.update_index];
    assign useful_max  = (useful_cur == {UW{1'b1}});
    assign useful_zero = (useful_cur == '0);

    //////////////////////////////
    // lookup read
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            port.hit <= 1'b0;
        end else begin
            port.hit <= valid_q[port.index] && (tag_q[port.index] == port.tag);
        end
    end

    always_ff @(posedge clk) begin
        port.ctr    <= ctr_q[port.index];
        port.useful <= useful_q[port.index];
    end

    //////////////////////////////
    // tag and counter write
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (port.update_en) begin
            tag_q[port.update_index] <= port.update_tag;
            ctr_q[port.update_index] <= port.update_ctr;
        end
    end

    //////////////////////////////
    // valid and useful upkeep
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ENTRIES; i++) begin
                valid_q[i]  <= 1'b0;
                useful_q[i] <= '0;
            end
        end else begin
            if (port.update_en) begin
                valid_q[port.update_index] <= 1'b1;
            end

            if (port.reset_useful) begin
                useful_q[port.update_index] <= '0;  // fresh allocation
            end else if (port.inc_useful && !useful_max) begin
                useful_q[port.update_index] <= useful_cur + 1'b1;
            end else if (port.dec_useful && !useful_zero) begin
                useful_q[port.update_index] <= useful_cur - 1'b1;
            end

            // periodic aging, overrides the per-entry update above
            for (int i = 0; i < ENTRIES; i++) begin
                if (flush_ubits_hi) begin
                    useful_q[i][UW-1] <= 1'b0;
                end
                if (flush_ubits_lo) begin
                    useful_q[i][0] <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/tage_bank_if.sv */
`default_nettype none

interface tage_bank_if;

    // lookup, from the hash
    tage_pkg::tage_index_t  index;
    tage_pkg::tage_tag_t    tag;

    // response, one cycle later
    tage_pkg::tage_ctr_t    ctr;
    tage_pkg::tage_useful_t useful;
    logic                   hit;

    // update, from commit side
    logic                   update_en;    // write tag and counter, set valid
    tage_pkg::tage_ctr_t    update_ctr;
    tage_pkg::tage_index_t  update_index; // also selects the useful entry
    tage_pkg::tage_tag_t    update_tag;
    logic                   inc_useful;
    logic                   dec_useful;
    logic                   reset_useful;

    modport bank (
        input  index, tag,
        input  update_en, update_ctr, update_index, update_tag,
        input  inc_useful, dec_useful, reset_useful,
        output ctr, useful, hit
    );

    modport ctrl (
        output index, tag,
        output update_en, update_ctr, update_index, update_tag,
        output inc_useful, dec_useful, reset_useful,
        input  ctr, useful, hit
    );

endinterface

`default_nettype wire

/* hw/tage_hist_hash.sv */
`default_nettype none

`include "tage_consts.svh"

module tage_hist_hash (
    input  wire        clk,
    input  wire        reset,
    input  wire        pause,
    input  wire        recover,
    input  wire [31:0] lookup_pc,
    input  wire        spec_shift,
    input  wire        spec_taken,
    input  wire        commit_valid,
    input  wire        commit_taken,
    tage_bank_if.ctrl  bank [`TAGE_BANKS]
);

    localparam int HW = `TAGE_HIST_LEN_3;
    localparam int IW = `TAGE_INDEX_W;
    localparam int TW = `TAGE_TAG_W;
    localparam int FW = (TW > IW) ? TW : IW; // widest fold result
    localparam int HIST_LEN [`TAGE_BANKS] = '{
        `TAGE_HIST_LEN_0, `TAGE_HIST_LEN_1, `TAGE_HIST_LEN_2, `TAGE_HIST_LEN_3
    };

    logic [HW-1:0] spec_hist;   // bit 0 is the newest outcome
    logic [HW-1:0] commit_hist;

    // xor the first len bits of history down to w bits
    function automatic logic [FW-1:0] fold(input logic [HW-1:0] hist, input int len,
                                           input int w);
        logic [FW-1:0] acc;
        acc = '0;
        for (int i = 0; i < HW; i++) begin
            if (i < len) begin
                acc[i % w] = acc[i % w] ^ hist[i];
            end
        end
        return acc;
    endfunction

    //////////////////////////////
    // history registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            spec_hist   <= '0;
            commit_hist <= '0;
        end else begin
            if (commit_valid) begin
                commit_hist <= {commit_hist[HW-2:0], commit_taken};
            end
            if (recover) begin
                spec_hist <= commit_hist;   // wins over a pending shift
            end else if (spec_shift && !pause) begin
                spec_hist <= {spec_hist[HW-2:0], spec_taken};
            end
        end
    end

    //////////////////////////////
    // per-bank index and tag
    //////////////////////////////

    for (genvar g = 0; g < `TAGE_BANKS; g++) begin : g_hash
        logic [FW-1:0]          fold_i;
        logic [FW-1:0]          fold_t0;
        logic [FW-1:0]          fold_t1;
        tage_pkg::tage_index_t  idx_hash;
        tage_pkg::tage_tag_t    tag_hash;
        tage_pkg::tage_index_t  idx_hold;
        tage_pkg::tage_tag_t    tag_hold;

        assign fold_i  = fold(spec_hist, HIST_LEN[g], IW);
        assign fold_t0 = fold(spec_hist, HIST_LEN[g], TW);
        assign fold_t1 = fold(spec_hist, HIST_LEN[g], TW - 1);

        // each bank mixes in its own pc slice
        assign idx_hash = lookup_pc[2 +: IW] ^ lookup_pc[(2 + IW + g) +: IW] ^ fold_i[IW-1:0];
        assign tag_hash = lookup_pc[(12 + g) +: TW] ^ fold_t0[TW-1:0] ^ {fold_t1[TW-2:0], 1'b0};

        // last issued address, replayed while paused
        always_ff @(posedge clk) begin
            if (!pause) begin
                idx_hold <= idx_hash;
                tag_hold <= tag_hash;
            end
        end

        assign bank[g].index = pause ? idx_hold : idx_hash;
        assign bank[g].tag   = pause ? tag_hold : tag_hash;
    end

endmodule

`default_nettype wire

/* hw/tage_pkg.sv */
`default_nettype none

`include "tage_consts.svh"

package tage_pkg;

    // per-bank field types
    typedef logic [`TAGE_INDEX_W-1:0]  tage_index_t;
    typedef logic [`TAGE_TAG_W-1:0]    tage_tag_t;
    typedef logic [`TAGE_CTR_W-1:0]    tage_ctr_t;
    typedef logic [`TAGE_USEFUL_W-1:0] tage_useful_t;

    // prediction record
    // returned with every prediction and handed back as is on commit,
    // so training and allocation work on the state seen at lookup time
    typedef struct packed {
        logic [`TAGE_BANKS-1:0]         hit;            // tag match per bank
        logic [1:0]                     provider;       // longest hitting bank
        logic                           provider_valid; // any bank hit
        logic                           has_alter;      // a shorter bank hit too
        tage_ctr_t [`TAGE_BANKS-1:0]    ctr;
        tage_useful_t [`TAGE_BANKS-1:0] useful;
        tage_index_t [`TAGE_BANKS-1:0]  index;          // where each bank was read
        tage_tag_t [`TAGE_BANKS-1:0]    tag;            // tag compared in each bank
    } tage_pred_t;

endpackage

`default_nettype wire

/* hw/tage_predictor.sv */
`default_nettype none

`include "tage_consts.svh"

module tage_predictor (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       pause,
    input  wire                       recover,
    input  wire                       flush_ubits_hi,
    input  wire                       flush_ubits_lo,
    input  wire                       lookup_valid,
    input  wire [31:0]                lookup_pc,
    output logic                      pred_valid,
    output logic                      pred_taken,
    output logic                      pred_hit,
    output tage_pkg::tage_pred_t      pred_info,
    input  wire                       commit_valid,
    input  wire [31:0]                commit_pc,
    input  wire                       commit_taken,
    input  wire                       commit_mispred,
    input  wire tage_pkg::tage_pred_t commit_info
);

    localparam int NB = `TAGE_BANKS;

    tage_bank_if bank_if [NB] ();

    logic [NB-1:0]                   hit_vec;
    tage_pkg::tage_ctr_t [NB-1:0]    ctr_vec;
    tage_pkg::tage_useful_t [NB-1:0] useful_vec;
    tage_pkg::tage_index_t [NB-1:0]  idx_q;     // address of the bank read
    tage_pkg::tage_tag_t [NB-1:0]    tag_q;
    logic [1:0]                      provider;
    logic                            provider_valid;
    logic [NB-1:0]                   alt_mask;  // hits shorter than the provider
    logic                            has_alter;

    tage_hist_hash u_hash (
        .clk          (clk),
        .reset        (reset),
        .pause        (pause),
        .recover      (recover),
        .lookup_pc    (lookup_pc),
        .spec_shift   (pred_valid),
        .spec_taken   (pred_taken),
        .commit_valid (commit_valid),
        .commit_taken (commit_taken),
        .bank         (bank_if)
    );

    for (genvar g = 0; g < NB; g++) begin : g_bank
        tage_bank u_bank (
            .clk            (clk),
            .reset          (reset),
            .flush_ubits_hi (flush_ubits_hi),
            .flush_ubits_lo (flush_ubits_lo),
            .port           (bank_if[g])
        );

        assign hit_vec[g]    = bank_if[g].hit;
        assign ctr_vec[g]    = bank_if[g].ctr;
        assign useful_vec[g] = bank_if[g].useful;

        always_ff @(posedge clk) begin
            if (!pause) begin
                idx_q[g] <= bank_if[g].index;
                tag_q[g] <= bank_if[g].tag;
            end
        end
    end

    tage_update u_update (
        .clk            (clk),
        .reset          (reset),
        .commit_valid   (commit_valid),
        .commit_taken   (commit_taken),
        .commit_mispred (commit_mispred),
        .commit_info    (commit_info),
        .bank           (bank_if)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            pred_valid <= 1'b0;
        end else if (!pause) begin
            pred_valid <= lookup_valid;
        end
    end

    //////////////////////////////
    // provider and alternate
    //////////////////////////////

    always_comb begin
        provider = '0;
        for (int g = 0; g < NB; g++) begin
            if (hit_vec[g]) begin
                provider = 2'(g); // longest history wins
            end
        end
    end

    assign provider_valid = |hit_vec;
    assign alt_mask       = hit_vec & ~(NB'(1) << provider);
    assign has_alter      = provider_valid && (|alt_mask);

    assign pred_hit   = provider_valid;
    assign pred_taken = provider_valid ? ctr_vec[provider][`TAGE_CTR_W-1] : 1'b0;

    always_comb begin
        pred_info                = '0;
        pred_info.hit            = hit_vec;
        pred_info.provider       = provider;
        pred_info.provider_valid = provider_valid;
        pred_info.has_alter      = has_alter;
        pred_info.ctr            = ctr_vec;
        pred_info.useful         = useful_vec;
        pred_info.index          = idx_q;
        pred_info.tag            = tag_q;
    end

endmodule

`default_nettype wire

/* hw/tage_update.sv */
`default_nettype none

`include "tage_consts.svh"

module tage_update (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  commit_valid,
    input  wire                  commit_taken,
    input  wire                  commit_mispred,
    input  wire tage_pkg::tage_pred_t commit_info,
    tage_bank_if.ctrl            bank [`TAGE_BANKS]
);

    localparam int NB = `TAGE_BANKS;
    localparam int CW = `TAGE_CTR_W;
    localparam logic [7:0]    LFSR_SEED  = 8'hff;
    localparam logic [7:0]    LFSR_TAPS  = 8'hb8;  // x^8 + x^6 + x^5 + x^4 + 1
    localparam logic [7:0]    ALT_THRESH = 8'd170; // about a third of draws take the 2nd
    localparam logic [CW-1:0] CTR_MAX    = {CW{1'b1}};
    localparam logic [CW-1:0] CTR_WEAK_T = {1'b1, {(CW-1){1'b0}}};
    localparam logic [CW-1:0] CTR_WEAK_N = {1'b0, {(CW-1){1'b1}}};

    logic [7:0]                 lfsr_q;
    logic [NB-1:0]              cand;       // banks longer than the provider
    logic [NB-1:0]              free_vec;
    logic [1:0]                 first_free;
    logic [1:0]                 second_free;
    logic                       has_first;
    logic                       has_second;
    logic [1:0]                 alloc_bank;
    tage_pkg::tage_ctr_t        prov_ctr;
    tage_pkg::tage_ctr_t        trained_ctr;
    tage_pkg::tage_ctr_t        alloc_ctr;
    logic [NB-1:0]              upd_en;
    logic [NB-1:0]              upd_inc;
    logic [NB-1:0]              upd_dec;
    logic [NB-1:0]              upd_rst;

    // galois lfsr, free running
    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr_q <= LFSR_SEED;
        end else begin
            lfsr_q <= {1'b0, lfsr_q[7:1]} ^ (lfsr_q[0] ? LFSR_TAPS : 8'h00);
        end
    end

    //////////////////////////////
    // allocation choice
    //////////////////////////////

    for (genvar g = 0; g < NB; g++) begin : g_cand
        assign cand[g]     = !commit_info.provider_valid || (commit_info.provider < 2'(g));
        assign free_vec[g] = cand[g] && (commit_info.useful[g] == '0);
    end

    always_comb begin
        first_free  = '0;
        second_free = '0;
        has_first   = 1'b0;
        has_second  = 1'b0;
        for (int g = 0; g < NB; g++) begin
            if (free_vec[g]) begin
                if (!has_first) begin
                    first_free = 2'(g);
                    has_first  = 1'b1;
                end else if (!has_second) begin
                    second_free = 2'(g);
                    has_second  = 1'b1;
                end
            end
        end
    end

    assign alloc_bank = (has_second && lfsr_q >= ALT_THRESH) ? second_free : first_free;

    //////////////////////////////
    // training
    //////////////////////////////

    assign prov_ctr    = commit_info.ctr[commit_info.provider];
    assign trained_ctr = commit_taken ? ((prov_ctr == CTR_MAX) ? prov_ctr : prov_ctr + 1'b1)
                                      : ((prov_ctr == '0) ? prov_ctr : prov_ctr - 1'b1);
    assign alloc_ctr   = commit_taken ? CTR_WEAK_T : CTR_WEAK_N;

    always_comb begin
        upd_en  = '0;
        upd_inc = '0;
        upd_dec = '0;
        upd_rst = '0;
        if (commit_valid) begin
            if (commit_info.provider_valid) begin
                upd_en[commit_info.provider] = 1'b1;
                if (commit_info.has_alter) begin    // only then is usefulness known
                    upd_inc[commit_info.provider] = !commit_mispred;
                    upd_dec[commit_info.provider] = commit_mispred;
                end
            end
            if (commit_mispred) begin
                if (has_first) begin
                    upd_en[alloc_bank]  = 1'b1;
                    upd_rst[alloc_bank] = 1'b1;
                end else begin
                    upd_dec = upd_dec | cand; // age all longer banks instead
                end
            end
        end
    end

    // provider gets the trained value, any other written bank is a new entry
    for (genvar g = 0; g < NB; g++) begin : g_drive
        assign bank[g].update_en    = upd_en[g];
        assign bank[g].update_ctr   = (commit_info.provider_valid &&
                                       commit_info.provider == 2'(g)) ? trained_ctr : alloc_ctr;
        assign bank[g].update_index = commit_info.index[g];
        assign bank[g].update_tag   = commit_info.tag[g];
        assign bank[g].inc_useful   = upd_inc[g];
        assign bank[g].dec_useful   = upd_dec[g];
        assign bank[g].reset_useful = upd_rst[g];
    end

endmodule

`default_nettype wire

/* include/tage_consts.svh */
`ifndef TAGE_CONSTS_SVH
`define TAGE_CONSTS_SVH

//////////////////////////////
// table geometry
//////////////////////////////

`define TAGE_BANKS       4
`define TAGE_INDEX_W     8      // 256 entries per bank
`define TAGE_TAG_W       9
`define TAGE_CTR_W       3      // top bit is the direction
`define TAGE_USEFUL_W    2      // msb is the hi half, lsb the lo half

//////////////////////////////
// geometric history lengths
//////////////////////////////

`define TAGE_HIST_LEN_0  10
`define TAGE_HIST_LEN_1  20
`define TAGE_HIST_LEN_2  40
`define TAGE_HIST_LEN_3  80     // longest, also the history register width

`endif

/* tb.f */
+incdir+include
hw/tage_pkg.sv
hw/tage_bank_if.sv
hw/tage_hist_hash.sv
hw/tage_bank.sv
hw/tage_update.sv
hw/tage_predictor.sv
tests/tage_chk.sv
tests/tage_tb.sv

/* tests/tage_chk.sv */
`default_nettype none

`include "tage_consts.svh"

module tage_chk (
    input wire                       clk,
    input wire                       reset,
    input wire                       pause,
    input wire                       lookup_valid,
    input wire                       pred_valid,
    input wire                       pred_hit,
    input wire tage_pkg::tage_pred_t pred_info,
    input wire                       commit_valid,
    input wire                       commit_mispred,
    input wire tage_pkg::tage_pred_t commit_info,
    input wire [`TAGE_BANKS-1:0]     alloc_vec  // reset_useful per bank, one per new entry
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [`TAGE_BANKS-1:0] low_banks;  // provider and all shorter banks

    assign low_banks = commit_info.provider_valid ?
                       ((`TAGE_BANKS'(2) << commit_info.provider) - 1'b1) : '0;

    a_reset_quiet: assert property (@(posedge clk) reset |=> !pred_valid)
        else $error("pred_valid high just after reset");

    a_follow: assert property (@(posedge clk) disable iff (reset)
        !pause |=> pred_valid == $past(lookup_valid))
        else $error("pred_valid does not follow lookup_valid");

    a_hold: assert property (@(posedge clk) disable iff (reset)
        pause |=> $stable(pred_valid))
        else $error("pred_valid moved while paused");

    a_one_alloc: assert property (@(posedge clk) disable iff (reset)
        $onehot0(alloc_vec) && ((alloc_vec & low_banks) == '0) &&
        (alloc_vec == '0 || (commit_valid && commit_mispred)))
        else $error("allocation is not one bank above the provider on a mispredict");

    a_hit_provider: assert property (@(posedge clk) disable iff (reset)
        pred_hit |-> pred_info.hit[pred_info.provider])
        else $error("pred_hit without a hit in the provider bank");

endmodule

bind tage_predictor tage_chk u_chk (
    .clk            (clk),
    .reset          (reset),
    .pause          (pause),
    .lookup_valid   (lookup_valid),
    .pred_valid     (pred_valid),
    .pred_hit       (pred_hit),
    .pred_info      (pred_info),
    .commit_valid   (commit_valid),
    .commit_mispred (commit_mispred),
    .commit_info    (commit_info),
    .alloc_vec      (u_update.upd_rst)
);

`default_nettype wire

/* tests/tage_tb.sv */
`default_nettype none

module tage_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS       = 7;
    localparam int CYCLES_PER_TEST = 1000;
    localparam int WATCHDOG_NS     = (10 + NUM_TESTS * CYCLES_PER_TEST) * 4;

    logic clk, reset, pause, recover, flush_ubits_hi, flush_ubits_lo;
    logic lookup_valid, commit_valid, commit_taken, commit_mispred;
    logic [31:0] lookup_pc, commit_pc;
    logic pred_valid, pred_taken, pred_hit;
    tage_pkg::tage_pred_t pred_info, commit_info;

    logic [31:0]          lfsr_state;
    int                   error_count;
    logic                 last_taken;     // captured prediction
    logic                 last_hit;
    tage_pkg::tage_pred_t last_info;
    logic [31:0]          pc_a;
    logic [31:0]          pc_b;

    tage_predictor UUT (.*);

    always #2 clk = ~clk;

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog timeout, the tests did not finish in time");
        $display("Errors found");
        $fatal(1);
    end

    ////////////////////////////////
    // helpers
    ////////////////////////////////

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    task automatic random_pc(output logic [31:0] pc);
        for (int i = 0; i < 32; i++) begin
            pc[i]      = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
        pc[1:0] = 2'b00;   // word aligned
    endtask

    task automatic fail_now(input string msg);
        error_count++;
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_ctr(input string name, input tage_pkg::tage_ctr_t exp,
                             input tage_pkg::tage_ctr_t act);
        if (exp !== act) fail_now($sformatf("error %s ctr expected %0d actual %0d",
                                            name, exp, act));
    endtask

    task automatic check_useful(input string name, input tage_pkg::tage_useful_t exp,
                                input tage_pkg::tage_useful_t act);
        if (exp !== act) fail_now($sformatf("error %s useful expected %0d actual %0d",
                                            name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) fail_now($sformatf("error %s expected %0b actual %0b",
                                            name, exp, act));
    endtask

    task automatic lookup(input logic [31:0] pc);
        int waited;
        waited = 0;
        @(negedge clk);
        lookup_valid = 1'b1;
        lookup_pc    = pc;
        @(negedge clk);
        lookup_valid = 1'b0;
        while (!pred_valid && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (!pred_valid) fail_now("lookup got no pred_valid back");
        last_taken = pred_taken;
        last_hit   = pred_hit;
        last_info  = pred_info;
    endtask

    task automatic commit(input logic [31:0] pc, input logic taken, input logic mispred,
                          input tage_pkg::tage_pred_t info);
        @(negedge clk);
        commit_valid   = 1'b1;
        commit_pc      = pc;
        commit_taken   = taken;
        commit_mispred = mispred;
        commit_info    = info;
        @(negedge clk);
        commit_valid   = 1'b0;
        commit_mispred = 1'b0;
    endtask

    task automatic pulse_recover();
        @(negedge clk);
        recover = 1'b1;
        @(negedge clk);
        recover = 1'b0;
    endtask

    task automatic flush_useful(input logic hi);
        @(negedge clk);
        flush_ubits_hi = hi;
        flush_ubits_lo = !hi;
        @(negedge clk);
        flush_ubits_hi = 1'b0;
        flush_ubits_lo = 1'b0;
    endtask

    ////////////////////////////////
    // directed tests
    ////////////////////////////////

    task automatic test_reset_miss();
        logic [31:0] pc;
        for (int i = 0; i < 4; i++) begin
            random_pc(pc);
            lookup(pc);
            check_bit("reset_miss hit", 1'b0, last_hit);
            check_bit("reset_miss taken", 1'b0, last_taken);
        end
    endtask

    task automatic test_alloc();
        random_pc(pc_a);
        lookup(pc_a);
        check_bit("alloc first hit", 1'b0, last_hit);
        commit(pc_a, 1'b0, 1'b1, last_info);    // not taken keeps history at zero
        lookup(pc_a);
        check_bit("alloc hit", 1'b1, last_hit);
        check_bit("alloc taken", 1'b0, last_taken);
        check_ctr("alloc", 3'd3, last_info.ctr[last_info.provider]);
    endtask

    task automatic test_saturate_down();
        tage_pkg::tage_ctr_t exp;
        exp = 3'd3;
        for (int i = 0; i < 4; i++) begin
            commit(pc_a, 1'b0, 1'b0, last_info);
            lookup(pc_a);
            exp = (exp == 0) ? exp : exp - 1'b1;
            check_bit("saturate_down hit", 1'b1, last_hit);
            check_ctr("saturate_down", exp, last_info.ctr[last_info.provider]);
            check_bit("saturate_down taken", exp[2], last_taken);
        end
    endtask

    task automatic test_useful_flush();
        // mispredicts push new entries up until bank 3 provides
        for (int i = 0; i < 4 && last_info.provider != 2'd3; i++) begin
            commit(pc_a, 1'b0, 1'b1, last_info);
            lookup(pc_a);
        end
        if (!last_hit || last_info.provider != 2'd3)
            fail_now("useful_flush could not build an entry in bank 3");
        for (int i = 1; i <= 3; i++) begin
            commit(pc_a, 1'b0, 1'b0, last_info);
            lookup(pc_a);
            check_useful("useful_flush inc", 2'(i), last_info.useful[3]);
            check_ctr("useful_flush train", 3'(3 - i), last_info.ctr[3]);
        end
        flush_useful(1'b1);
        lookup(pc_a);
        check_useful("useful_flush hi", 2'd1, last_info.useful[3]);
        flush_useful(1'b0);
        lookup(pc_a);
        check_useful("useful_flush lo", 2'd0, last_info.useful[3]);
    endtask

    task automatic test_no_free_alloc();
        logic [31:0]          pc_alias;
        logic [3:0]           hits_before;
        for (int i = 0; i < 2; i++) begin
            commit(pc_a, 1'b0, 1'b0, last_info);
            lookup(pc_a);
        end
        check_useful("no_free setup", 2'd2, last_info.useful[3]);
        // bit 23 only feeds the bank 3 tag, same indices everywhere
        pc_alias = pc_a ^ 32'h0080_0000;
        lookup(pc_alias);
        check_bit("no_free bank3 miss", 1'b0, last_info.hit[3]);
        for (int i = 0; i < 3 && last_info.provider < 2'd2; i++) begin
            commit(pc_alias, 1'b0, 1'b1, last_info);
            lookup(pc_alias);
        end
        if (!last_hit || last_info.provider != 2'd2)
            fail_now("no_free could not get bank 2 as provider");
        check_useful("no_free before", 2'd2, last_info.useful[3]);
        hits_before = last_info.hit;
        commit(pc_alias, 1'b0, 1'b1, last_info);
        lookup(pc_alias);
        for (int g = 0; g < 4; g++) begin
            check_bit($sformatf("no_free hit[%0d]", g), hits_before[g], last_info.hit[g]);
        end
        check_useful("no_free aged", 2'd1, last_info.useful[3]);
    endtask

    task automatic test_saturate_up();
        tage_pkg::tage_ctr_t exp;
        @(negedge clk);
        commit_valid = 1'b1;                  // fill committed history with ones
        commit_taken = 1'b1;
        commit_info  = '0;
        repeat (80) @(negedge clk);
        commit_valid = 1'b0;
        pulse_recover();
        random_pc(pc_b);
        lookup(pc_b);
        check_bit("saturate_up first hit", 1'b0, last_hit);
        commit(pc_b, 1'b1, 1'b1, last_info);
        pulse_recover();                      // undo the zero shifted by the miss
        lookup(pc_b);
        check_bit("saturate_up hit", 1'b1, last_hit);
        check_ctr("saturate_up alloc", 3'd4, last_info.ctr[last_info.provider]);
        exp = 3'd4;
        for (int i = 0; i < 4; i++) begin
            commit(pc_b, 1'b1, 1'b0, last_info);
            lookup(pc_b);
            exp = (exp == 3'd7) ? exp : exp + 1'b1;
            check_ctr("saturate_up", exp, last_info.ctr[last_info.provider]);
            check_bit("saturate_up taken", exp[2], last_taken);
        end
    endtask

    task automatic test_recover();
        logic [31:0] pc_d;
        random_pc(pc_d);
        lookup(pc_d);
        check_bit("recover other taken", 1'b0, last_taken);
        lookup(pc_b);
        check_bit("recover shifted hit", 1'b0, last_hit);
        pulse_recover();
        lookup(pc_b);
        check_bit("recover hit", 1'b1, last_hit);
        check_bit("recover taken", 1'b1, last_taken);

        // a paused stage keeps the last read and ignores the new lookup
        @(negedge clk);
        pause        = 1'b1;
        lookup_valid = 1'b1;
        lookup_pc    = pc_d;
        repeat (2) @(negedge clk);
        check_bit("recover paused valid", 1'b0, pred_valid);
        check_bit("recover paused hit", 1'b1, pred_hit);
        check_bit("recover paused taken", 1'b1, pred_taken);
        pause = 1'b0;
        @(negedge clk);
        lookup_valid = 1'b0;
        check_bit("recover resumed valid", 1'b1, pred_valid);
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        pause = 1'b0;
        recover = 1'b0;
        flush_ubits_hi = 1'b0;
        flush_ubits_lo = 1'b0;
        lookup_valid = 1'b0;
        lookup_pc = '0;
        commit_valid = 1'b0;
        commit_pc = '0;
        commit_taken = 1'b0;
        commit_mispred = 1'b0;
        commit_info = '0;
        lfsr_state = 32'hfe0365a6;
        error_count = 0;
        repeat (10) @(negedge clk);
        reset = 1'b0;

        test_reset_miss();
        test_alloc();
        test_saturate_down();
        test_useful_flush();
        test_no_free_alloc();
        test_saturate_up();
        test_recover();

        if (error_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire
